//--- common/neuron_pkg.sv
// neuron_pkg: shared fp32 word type, neuron model encoding and reset defaults

package neuron_pkg;

    //**************************************************************************
    // single-precision word
    //**************************************************************************

    // ieee-754 layout, msb first
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] fraction;
    } fp32_t;

    //**************************************************************************
    // neuron models
    //**************************************************************************

    // code 2'b11 is unused and falls back to lif
    typedef enum logic [1:0] {
        model_lif        = 2'b00,
        model_izhikevich = 2'b01,
        model_qlif       = 2'b10
    } neuron_model_t;

    //**************************************************************************
    // reset defaults
    //**************************************************************************

    // threshold, about 45.88
    localparam fp32_t default_v_threshold = 32'h4237851f;

    // izhikevich parameters and u, about 67.89 each
    localparam fp32_t default_a = 32'h4287c7ae;
    localparam fp32_t default_b = 32'h4287c7ae;
    localparam fp32_t default_c = 32'h4287c7ae;
    localparam fp32_t default_d = 32'h4287c7ae;
    localparam fp32_t default_u = 32'h4287c7ae;

endpackage

//--- fp_arith/fp_add_sub.sv
// fp_add_sub: combinational fp32 add/subtract, truncating, flags exponent range errors
`timescale 1ns/100ps

module fp_add_sub (
    input  neuron_pkg::fp32_t a,
    input  neuron_pkg::fp32_t b,
    input  logic              subtract,
    output neuron_pkg::fp32_t result,
    output logic              exception
);

    // count of leading zeros in a 24-bit mantissa
    function automatic logic [4:0] lzc24(input logic [23:0] m);
        logic [4:0] n;
        logic       found;
        n = 5'd0;
        found = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            if (!found && !m[i]) begin
                n = n + 5'd1;
            end else begin
                found = 1'b1;
            end
        end
        return n;
    endfunction

    logic              b_sign;
    logic              swap;
    logic              big_sign;
    logic              small_sign;
    logic [7:0]        big_exp;
    logic [7:0]        small_exp;
    logic [23:0]       big_man;
    logic [23:0]       small_man;
    logic [7:0]        exp_diff;
    logic [23:0]       small_aligned;
    logic [24:0]       mag_sum;
    logic [23:0]       mag_diff;
    logic [4:0]        shift;
    logic [23:0]       norm_man;
    logic signed [9:0] res_exp;
    logic              res_zero;

    always_comb begin
        // effective sign of b after the operation select
        b_sign = b.sign ^ subtract;
        // larger magnitude goes first
        swap = ({b.exponent, b.fraction} > {a.exponent, a.fraction});
        big_sign   = swap ? b_sign : a.sign;
        small_sign = swap ? a.sign : b_sign;
        big_exp    = swap ? b.exponent : a.exponent;
        small_exp  = swap ? a.exponent : b.exponent;
        // exponent 0 means zero, no denormals
        big_man   = (big_exp == 8'd0) ? 24'd0 : {1'b1, (swap ? b.fraction : a.fraction)};
        small_man = (small_exp == 8'd0) ? 24'd0 : {1'b1, (swap ? a.fraction : b.fraction)};

        // align, shifted-out bits are dropped
        exp_diff = big_exp - small_exp;
        small_aligned = (exp_diff > 8'd23) ? 24'd0 : (small_man >> exp_diff);
        mag_sum  = {1'b0, big_man} + {1'b0, small_aligned};
        mag_diff = big_man - small_aligned;
        shift    = lzc24(mag_diff);

        if (big_sign == small_sign) begin
            // same signs, carry out moves the point by one
            res_zero = (mag_sum == 25'd0);
            if (mag_sum[24]) begin
                norm_man = mag_sum[24:1];
                res_exp  = {2'b00, big_exp} + 10'd1;
            end else begin
                norm_man = mag_sum[23:0];
                res_exp  = {2'b00, big_exp};
            end
        end else begin
            // opposite signs, renormalize after cancellation
            res_zero = (mag_diff == 24'd0);
            norm_man = mag_diff << shift;
            res_exp  = {2'b00, big_exp} - {5'd0, shift};
        end

        // exact zero is always +0
        exception = 1'b0;
        if (res_zero) begin
            result = '0;
        end else if (res_exp >= 10'sd255) begin
            // overflow, clamp to the largest finite value
            exception = 1'b1;
            result    = {big_sign, 8'hfe, 23'h7fffff};
        end else if (res_exp <= 10'sd0) begin
            // underflow flushes to zero
            exception = 1'b1;
            result    = '0;
        end else begin
            result = {big_sign, res_exp[7:0], norm_man[22:0]};
        end
    end

endmodule

//--- fp_arith/fp_mul.sv
// fp_mul: combinational fp32 multiplier, truncating, flags exponent range errors
`timescale 1ns/100ps

module fp_mul (
    input  neuron_pkg::fp32_t a,
    input  neuron_pkg::fp32_t b,
    output neuron_pkg::fp32_t result,
    output logic              exception
);

    logic              res_sign;
    logic              any_zero;
    logic [47:0]       product;
    logic [22:0]       res_frac;
    logic signed [9:0] res_exp;

    always_comb begin
        res_sign = a.sign ^ b.sign;
        // exponent 0 is treated as zero
        any_zero = (a.exponent == 8'd0) || (b.exponent == 8'd0);
        // 24x24 mantissa product with hidden bits
        product = {24'd0, 1'b1, a.fraction} * {24'd0, 1'b1, b.fraction};
        // biased sum with one bias removed
        res_exp = {2'b00, a.exponent} + {2'b00, b.exponent} - 10'd127;

        // product in [1,4) needs at most one normalize shift
        if (product[47]) begin
            res_frac = product[46:24];
            res_exp  = res_exp + 10'sd1;
        end else begin
            res_frac = product[45:23];
        end

        exception = 1'b0;
        if (any_zero) begin
            result = '0;
        end else if (res_exp >= 10'sd255) begin
            // clamp to largest finite
            exception = 1'b1;
            result    = {res_sign, 8'hfe, 23'h7fffff};
        end else if (res_exp <= 10'sd0) begin
            // flush to zero
            exception = 1'b1;
            result    = '0;
        end else begin
            result = {res_sign, res_exp[7:0], res_frac};
        end
    end

endmodule

//--- verilog/integrate_unit.sv
// integrate_unit: forms the lif, izhikevich and qlif candidate potentials of one sample
`timescale 1ns/100ps

module integrate_unit (
    input  neuron_pkg::fp32_t weight,
    input  neuron_pkg::fp32_t potential_in,
    input  neuron_pkg::fp32_t u_value,
    output neuron_pkg::fp32_t cand_lif,
    output neuron_pkg::fp32_t cand_izh,
    output neuron_pkg::fp32_t cand_qlif,
    output logic              integ_exception
);

    neuron_pkg::fp32_t v_squared;
    logic              exc_lif;
    logic              exc_izh;
    logic              exc_sq;
    logic              exc_qlif;

    // lif: v + w
    fp_add_sub add_vw_inst (
        .a         (potential_in),
        .b         (weight),
        .subtract  (1'b0),
        .result    (cand_lif),
        .exception (exc_lif)
    );

    // izhikevich: (v + w) - u
    fp_add_sub sub_u_inst (
        .a         (cand_lif),
        .b         (u_value),
        .subtract  (1'b1),
        .result    (cand_izh),
        .exception (exc_izh)
    );

    // qlif: v*v, then + w
    fp_mul mul_vv_inst (
        .a         (potential_in),
        .b         (potential_in),
        .result    (v_squared),
        .exception (exc_sq)
    );

    fp_add_sub add_qw_inst (
        .a         (v_squared),
        .b         (weight),
        .subtract  (1'b0),
        .result    (cand_qlif),
        .exception (exc_qlif)
    );

    // any range error in the three paths
    assign integ_exception = exc_lif | exc_izh | exc_sq | exc_qlif;

endmodule

//--- verilog/recovery_unit.sv
// recovery_unit: keeps the izhikevich recovery variable u and computes its update
`timescale 1ns/100ps

module recovery_unit (
    input  logic              CLK_Adder1,
    input  logic              rst_n,
    input  logic              cfg_valid,
    input  neuron_pkg::fp32_t param_a,
    input  neuron_pkg::fp32_t param_b,
    input  neuron_pkg::fp32_t param_d,
    input  neuron_pkg::fp32_t u_init,
    input  logic              sample_valid,
    input  neuron_pkg::fp32_t potential_in,
    input  logic              spike_now,
    input  logic              izh_active,
    output neuron_pkg::fp32_t u_value,
    output logic              recov_exception
);

    neuron_pkg::fp32_t a_q;
    neuron_pkg::fp32_t b_q;
    neuron_pkg::fp32_t d_q;
    neuron_pkg::fp32_t bv;
    neuron_pkg::fp32_t bv_minus_u;
    neuron_pkg::fp32_t a_term;
    neuron_pkg::fp32_t u_spiked;
    neuron_pkg::fp32_t u_rest;
    logic [4:0]        exc;

    //**************************************************************************
    // u update datapath
    //**************************************************************************

    // after a spike: u + d
    fp_add_sub add_d_inst (
        .a (u_value), .b (d_q), .subtract (1'b0), .result (u_spiked), .exception (exc[0])
    );

    // no spike: u + a*(b*v - u)
    fp_mul mul_bv_inst (
        .a (b_q), .b (potential_in), .result (bv), .exception (exc[1])
    );

    fp_add_sub sub_u_inst (
        .a (bv), .b (u_value), .subtract (1'b1), .result (bv_minus_u), .exception (exc[2])
    );

    fp_mul mul_a_inst (
        .a (a_q), .b (bv_minus_u), .result (a_term), .exception (exc[3])
    );

    fp_add_sub add_rest_inst (
        .a (u_value), .b (a_term), .subtract (1'b0), .result (u_rest), .exception (exc[4])
    );

    // only meaningful when the izhikevich model runs
    assign recov_exception = izh_active & (|exc);

    //**************************************************************************
    // state
    //**************************************************************************

    always_ff @(posedge CLK_Adder1 or negedge rst_n) begin
        if (!rst_n) begin
            a_q     <= neuron_pkg::default_a;
            b_q     <= neuron_pkg::default_b;
            d_q     <= neuron_pkg::default_d;
            u_value <= neuron_pkg::default_u;
        end else if (cfg_valid) begin
            a_q     <= param_a;
            b_q     <= param_b;
            d_q     <= param_d;
            u_value <= u_init;
        end else if (sample_valid && izh_active) begin
            // commit at the capture edge, next sample sees new u
            u_value <= spike_now ? u_spiked : u_rest;
        end
    end

endmodule

//--- verilog/spike_unit.sv
// spike_unit: threshold compare, reset value select and registered neuron outputs
`timescale 1ns/100ps

module spike_unit (
    input  logic                      CLK_Adder1,
    input  logic                      rst_n,
    input  logic                      cfg_valid,
    input  neuron_pkg::neuron_model_t cfg_model,
    input  neuron_pkg::fp32_t         v_threshold,
    input  neuron_pkg::fp32_t         param_c,
    input  logic                      sample_valid,
    input  neuron_pkg::fp32_t         cand_lif,
    input  neuron_pkg::fp32_t         cand_izh,
    input  neuron_pkg::fp32_t         cand_qlif,
    input  logic                      integ_exception,
    input  logic                      recov_exception,
    output logic                      spike_now,
    output logic                      izh_active,
    output neuron_pkg::fp32_t         potential_out,
    output logic                      spike,
    output logic                      done,
    output logic                      arith_exception
);

    neuron_pkg::neuron_model_t model_q;
    neuron_pkg::fp32_t         vth_q;
    neuron_pkg::fp32_t         c_q;
    neuron_pkg::fp32_t         cand_sel;
    neuron_pkg::fp32_t         over_value;
    neuron_pkg::fp32_t         next_potential;
    logic                      sub_exception;
    logic                      next_exception;

    // sign-magnitude a > b, +0 and -0 compare equal
    function automatic logic fp_gt(input neuron_pkg::fp32_t x, input neuron_pkg::fp32_t y);
        logic both_zero;
        both_zero = (x.exponent == 8'd0) && (y.exponent == 8'd0);
        if (both_zero) begin
            return 1'b0;
        end else if (x.sign != y.sign) begin
            return !x.sign;
        end else if (!x.sign) begin
            return x[30:0] > y[30:0];
        end else begin
            return x[30:0] < y[30:0];
        end
    endfunction

    // candidate for the active model, spare code acts as lif
    always_comb begin
        case (model_q)
            neuron_pkg::model_izhikevich: cand_sel = cand_izh;
            neuron_pkg::model_qlif:       cand_sel = cand_qlif;
            default:                      cand_sel = cand_lif;
        endcase
    end

    assign izh_active = (model_q == neuron_pkg::model_izhikevich);
    assign spike_now  = fp_gt(cand_sel, vth_q);

    // lif and qlif subtract the threshold on a spike
    fp_add_sub sub_vth_inst (
        .a         (cand_sel),
        .b         (vth_q),
        .subtract  (1'b1),
        .result    (over_value),
        .exception (sub_exception)
    );

    always_comb begin
        if (!spike_now) begin
            next_potential = cand_sel;
        end else if (izh_active) begin
            next_potential = c_q;
        end else begin
            next_potential = over_value;
        end
        next_exception = integ_exception | recov_exception
                       | (spike_now & ~izh_active & sub_exception);
    end

    //**************************************************************************
    // configuration and output registers
    //**************************************************************************

    always_ff @(posedge CLK_Adder1 or negedge rst_n) begin
        if (!rst_n) begin
            model_q <= neuron_pkg::model_lif;
            vth_q   <= neuron_pkg::default_v_threshold;
            c_q     <= neuron_pkg::default_c;
        end else if (cfg_valid) begin
            model_q <= cfg_model;
            vth_q   <= v_threshold;
            c_q     <= param_c;
        end
    end

    // results hold until the next sample
    always_ff @(posedge CLK_Adder1 or negedge rst_n) begin
        if (!rst_n) begin
            done            <= 1'b0;
            spike           <= 1'b0;
            potential_out   <= '0;
            arith_exception <= 1'b0;
        end else begin
            done <= sample_valid;
            if (sample_valid) begin
                spike           <= spike_now;
                potential_out   <= next_potential;
                arith_exception <= next_exception;
            end
        end
    end

    // config and sample strobes never overlap, u and model would race
    assert property (@(posedge CLK_Adder1) disable iff (!rst_n)
        !(cfg_valid && sample_valid));

    // done answers exactly one cycle after a strobe
    assert property (@(posedge CLK_Adder1) disable iff (!rst_n)
        done |-> $past(sample_valid));

endmodule

//--- verilog/neuron_core.sv
// neuron_core: spiking neuron update, integrate and recovery units feeding the spike unit
`timescale 1ns/100ps

module neuron_core (
    input  logic                      CLK_Adder1,
    input  logic                      rst_n,
    input  logic                      sample_valid,
    input  neuron_pkg::fp32_t         weight,
    input  neuron_pkg::fp32_t         potential_in,
    input  logic                      cfg_valid,
    input  neuron_pkg::neuron_model_t cfg_model,
    input  neuron_pkg::fp32_t         v_threshold,
    input  neuron_pkg::fp32_t         param_a,
    input  neuron_pkg::fp32_t         param_b,
    input  neuron_pkg::fp32_t         param_c,
    input  neuron_pkg::fp32_t         param_d,
    input  neuron_pkg::fp32_t         u_init,
    output neuron_pkg::fp32_t         potential_out,
    output logic                      spike,
    output logic                      done,
    output logic                      arith_exception
);

    neuron_pkg::fp32_t u_value;
    neuron_pkg::fp32_t cand_lif;
    neuron_pkg::fp32_t cand_izh;
    neuron_pkg::fp32_t cand_qlif;
    logic              integ_exception;
    logic              recov_exception;
    logic              spike_now;
    logic              izh_active;

    // candidates, pure combinational
    integrate_unit integrate_unit_inst (
        .weight          (weight),
        .potential_in    (potential_in),
        .u_value         (u_value),
        .cand_lif        (cand_lif),
        .cand_izh        (cand_izh),
        .cand_qlif       (cand_qlif),
        .integ_exception (integ_exception)
    );

    // u runs beside the integrate path
    recovery_unit recovery_unit_inst (
        .CLK_Adder1      (CLK_Adder1),
        .rst_n           (rst_n),
        .cfg_valid       (cfg_valid),
        .param_a         (param_a),
        .param_b         (param_b),
        .param_d         (param_d),
        .u_init          (u_init),
        .sample_valid    (sample_valid),
        .potential_in    (potential_in),
        .spike_now       (spike_now),
        .izh_active      (izh_active),
        .u_value         (u_value),
        .recov_exception (recov_exception)
    );

    spike_unit spike_unit_inst (
        .CLK_Adder1      (CLK_Adder1),
        .rst_n           (rst_n),
        .cfg_valid       (cfg_valid),
        .cfg_model       (cfg_model),
        .v_threshold     (v_threshold),
        .param_c         (param_c),
        .sample_valid    (sample_valid),
        .cand_lif        (cand_lif),
        .cand_izh        (cand_izh),
        .cand_qlif       (cand_qlif),
        .integ_exception (integ_exception),
        .recov_exception (recov_exception),
        .spike_now       (spike_now),
        .izh_active      (izh_active),
        .potential_out   (potential_out),
        .spike           (spike),
        .done            (done),
        .arith_exception (arith_exception)
    );

endmodule

//--- testbench/neuron_core_checks.svh
// neuron_core_checks: compare tasks for potential, spike, done and exception results
`ifndef neuron_core_checks_svh
`define neuron_core_checks_svh

// fp32 potential, bit exact
task automatic check_potential(input string             test_name,
                               input neuron_pkg::fp32_t expected,
                               input neuron_pkg::fp32_t actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s: potential expected %h actual %h",
                 test_name, expected, actual);
        error_count++;
    end
endtask

task automatic check_spike(input string test_name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s: spike expected %b actual %b", test_name, expected, actual);
        error_count++;
    end
endtask

task automatic check_done(input string test_name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s: done expected %b actual %b", test_name, expected, actual);
        error_count++;
    end
endtask

// range error flag of the fp datapath
task automatic check_exception(input string test_name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s: arith_exception expected %b actual %b",
                 test_name, expected, actual);
        error_count++;
    end
endtask

`endif

//--- testbench/neuron_core_tb.sv
// neuron_core_tb: directed and random tests of the spiking neuron update block
`timescale 1ns/100ps

module neuron_core_tb;

    logic                      CLK_Adder1 = 1'b0;
    logic                      rst_n;
    logic                      sample_valid;
    neuron_pkg::fp32_t         weight;
    neuron_pkg::fp32_t         potential_in;
    logic                      cfg_valid;
    neuron_pkg::neuron_model_t cfg_model;
    neuron_pkg::fp32_t         v_threshold;
    neuron_pkg::fp32_t         param_a;
    neuron_pkg::fp32_t         param_b;
    neuron_pkg::fp32_t         param_c;
    neuron_pkg::fp32_t         param_d;
    neuron_pkg::fp32_t         u_init;
    neuron_pkg::fp32_t         potential_out;
    logic                      spike;
    logic                      done;
    logic                      arith_exception;

    int error_count   = 0;
    int timeout_count = 0;
    int done_pulses   = 0;
    int seed          = 88994;

    // izhikevich reference state and parameters
    real u_model;
    localparam real izh_a   = 0.5;
    localparam real izh_b   = 0.25;
    localparam real izh_c   = -2.0;
    localparam real izh_d   = 2.0;
    localparam real izh_vth = 10.0;
    localparam int  done_timeout = 20;

    `include "neuron_core_checks.svh"

    neuron_core neuron_core_inst (
        .CLK_Adder1      (CLK_Adder1),
        .rst_n           (rst_n),
        .sample_valid    (sample_valid),
        .weight          (weight),
        .potential_in    (potential_in),
        .cfg_valid       (cfg_valid),
        .cfg_model       (cfg_model),
        .v_threshold     (v_threshold),
        .param_a         (param_a),
        .param_b         (param_b),
        .param_c         (param_c),
        .param_d         (param_d),
        .u_init          (u_init),
        .potential_out   (potential_out),
        .spike           (spike),
        .done            (done),
        .arith_exception (arith_exception)
    );

    // 10 ns period
    always #5 CLK_Adder1 = ~CLK_Adder1;

    // done is stable at the falling edge
    always @(negedge CLK_Adder1) begin
        if (done) begin
            done_pulses++;
        end
    end

    //**************************************************************************
    // real <-> fp32 conversion through the double layout
    //**************************************************************************

    function automatic neuron_pkg::fp32_t real_to_fp(input real r);
        logic [63:0] bits;
        logic [10:0] exp_s;
        bits  = $realtobits(r);
        // rebias 1023 -> 127
        exp_s = bits[62:52] - 11'd896;
        if (bits[62:52] == 11'd0) begin
            return '0;
        end
        return {bits[63], exp_s[7:0], bits[51:29]};
    endfunction

    function automatic real fp_to_real(input neuron_pkg::fp32_t x);
        logic [10:0] exp_d;
        exp_d = {3'b000, x.exponent} + 11'd896;
        if (x.exponent == 8'd0) begin
            return 0.0;
        end
        return $bitstoreal({x.sign, exp_d, x.fraction, 29'd0});
    endfunction

    //**************************************************************************
    // stimulus helpers
    //**************************************************************************

    task automatic configure(input neuron_pkg::neuron_model_t model, input real vth,
                             input real a, input real b, input real c,
                             input real d, input real u);
        @(negedge CLK_Adder1);
        cfg_valid   = 1'b1;
        cfg_model   = model;
        v_threshold = real_to_fp(vth);
        param_a     = real_to_fp(a);
        param_b     = real_to_fp(b);
        param_c     = real_to_fp(c);
        param_d     = real_to_fp(d);
        u_init      = real_to_fp(u);
        @(negedge CLK_Adder1);
        cfg_valid = 1'b0;
    endtask

    // bounded polling at falling edges
    task automatic wait_for_done(input string name);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < done_timeout) begin
            @(negedge CLK_Adder1);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("ERROR %s: done did not arrive within %0d cycles", name, done_timeout);
            timeout_count++;
        end
    endtask

    task automatic apply_sample(input string name, input real v, input real w);
        @(negedge CLK_Adder1);
        sample_valid = 1'b1;
        potential_in = real_to_fp(v);
        weight       = real_to_fp(w);
        @(negedge CLK_Adder1);
        sample_valid = 1'b0;
        wait_for_done(name);
    endtask

    task automatic compare_outputs(input string name, input neuron_pkg::fp32_t exp_pot,
                                   input logic exp_spk, input logic exp_exc);
        check_potential(name, exp_pot, potential_out);
        check_spike(name, exp_spk, spike);
        check_exception(name, exp_exc, arith_exception);
    endtask

    // lif and qlif rule subtracts vth above threshold
    task automatic threshold_sample(input string name, input real v, input real w,
                                    input real vth, input logic square);
        real  cand;
        logic exp_spk;
        cand    = square ? (v * v + w) : (v + w);
        exp_spk = (cand > vth);
        apply_sample(name, v, w);
        compare_outputs(name, real_to_fp(exp_spk ? cand - vth : cand), exp_spk, 1'b0);
    endtask

    // izhikevich rule that also advances the reference u
    task automatic izh_expect(input real v, input real w,
                              output neuron_pkg::fp32_t exp_pot, output logic exp_spk);
        real cand;
        cand    = v + w - u_model;
        exp_spk = (cand > izh_vth);
        if (exp_spk) begin
            exp_pot = real_to_fp(izh_c);
            u_model = u_model + izh_d;
        end else begin
            exp_pot = real_to_fp(cand);
            u_model = u_model + izh_a * (izh_b * v - u_model);
        end
    endtask

    task automatic izh_sample(input string name, input real v, input real w);
        neuron_pkg::fp32_t exp_pot;
        logic              exp_spk;
        izh_expect(v, w, exp_pot, exp_spk);
        apply_sample(name, v, w);
        compare_outputs(name, exp_pot, exp_spk, 1'b0);
    endtask

    // two strobes in consecutive cycles
    task automatic izh_back_to_back(input real v0, input real w0, input real v1, input real w1);
        neuron_pkg::fp32_t pot0;
        neuron_pkg::fp32_t pot1;
        logic              spk0;
        logic              spk1;
        izh_expect(v0, w0, pot0, spk0);
        izh_expect(v1, w1, pot1, spk1);
        @(negedge CLK_Adder1);
        sample_valid = 1'b1;
        potential_in = real_to_fp(v0);
        weight       = real_to_fp(w0);
        @(negedge CLK_Adder1);
        potential_in = real_to_fp(v1);
        weight       = real_to_fp(w1);
        // first result is out after exactly one edge
        check_done("izh_b2b_first", 1'b1, done);
        compare_outputs("izh_b2b_first", pot0, spk0, 1'b0);
        @(negedge CLK_Adder1);
        sample_valid = 1'b0;
        wait_for_done("izh_b2b_second");
        compare_outputs("izh_b2b_second", pot1, spk1, 1'b0);
    endtask

    //**************************************************************************
    // directed tests
    //**************************************************************************

    task automatic verify_reset_state();
        real vth_default;
        vth_default = fp_to_real(neuron_pkg::default_v_threshold);
        check_done("reset_state", 1'b0, done);
        compare_outputs("reset_state", '0, 1'b0, 1'b0);
        // no cfg strobe yet so the default lif threshold applies
        threshold_sample("reset_lif_below", 40.0, 5.0, vth_default, 1'b0);
        threshold_sample("reset_lif_above", 40.0, 6.0, vth_default, 1'b0);
    endtask

    task automatic run_lif();
        configure(neuron_pkg::model_lif, 10.0, 1.0, 1.0, 1.0, 1.0, 1.0);
        threshold_sample("lif_below", 4.0, 3.0, 10.0, 1'b0);
        threshold_sample("lif_spike", 8.0, 5.0, 10.0, 1'b0);
    endtask

    task automatic run_izhikevich_sequence();
        configure(neuron_pkg::model_izhikevich, izh_vth, izh_a, izh_b, izh_c, izh_d, 1.0);
        u_model = 1.0;
        izh_sample("izh_rest", 4.0, 3.0);
        // second strobe sees u updated by the first
        izh_back_to_back(8.0, 2.0, 12.0, 1.0);
        izh_sample("izh_after_spike", 8.0, 4.0);
        izh_sample("izh_zero_v", 0.0, 5.0);
        izh_sample("izh_spike_again", 12.0, 3.0);
    endtask

    task automatic run_qlif();
        configure(neuron_pkg::model_qlif, 16.0, 1.0, 1.0, 1.0, 1.0, 1.0);
        threshold_sample("qlif_below", 3.0, 2.0, 16.0, 1'b1);
        threshold_sample("qlif_spike", 4.0, 1.0, 16.0, 1'b1);
    endtask

    task automatic random_lif_sweep();
        int w;
        int v;
        int pulses_start;
        configure(neuron_pkg::model_lif, 10.0, 1.0, 1.0, 1.0, 1.0, 1.0);
        pulses_start = done_pulses;
        for (int i = 0; i < 20; i++) begin
            // weight in -8..8 and potential in 0..8
            w = $random(seed) % 9;
            v = ($random(seed) & 32'h7fffffff) % 9;
            threshold_sample($sformatf("random_lif_%0d", i), real'(v), real'(w), 10.0, 1'b0);
        end
        @(negedge CLK_Adder1);
        if (done_pulses - pulses_start != 20) begin
            $display("CHECK FAILED random_lif_done: done pulses expected 20 actual %0d",
                     done_pulses - pulses_start);
            error_count++;
        end
    endtask

    task automatic overflow_exception();
        configure(neuron_pkg::model_qlif, 16.0, 1.0, 1.0, 1.0, 1.0, 1.0);
        // v*v lands near 2^201
        apply_sample("qlif_overflow", 1.5 * (2.0 ** 100), 1.0);
        check_exception("qlif_overflow", 1'b1, arith_exception);
        threshold_sample("qlif_after_overflow", 3.0, 2.0, 16.0, 1'b1);
    endtask

    //**************************************************************************
    // main sequence
    //**************************************************************************

    initial begin
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        weight       = '0;
        potential_in = '0;
        cfg_valid    = 1'b0;
        cfg_model    = neuron_pkg::model_lif;
        v_threshold  = '0;
        param_a      = '0;
        param_b      = '0;
        param_c      = '0;
        param_d      = '0;
        u_init       = '0;
        u_model      = 0.0;

        repeat (4) @(posedge CLK_Adder1);
        @(negedge CLK_Adder1);
        rst_n = 1'b1;

        verify_reset_state();
        run_lif();
        run_izhikevich_sequence();
        run_qlif();
        random_lif_sweep();
        overflow_exception();

        $display("neuron_core_tb: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- neuron_core.f
+incdir+testbench
common/neuron_pkg.sv
fp_arith/fp_add_sub.sv
fp_arith/fp_mul.sv
verilog/integrate_unit.sv
verilog/recovery_unit.sv
verilog/spike_unit.sv
verilog/neuron_core.sv
testbench/neuron_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the neuron_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module neuron_core_tb -f neuron_core.f \
    || { echo "run_sim: build failed"; exit 1; }

sim_out="$(./obj_dir/Vneuron_core_tb 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Result: PASSED" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
